// File: hdl/bridge_pkg.sv
package bridge_pkg;

    //////////////////////////////////////////////////
    // Host register access widths
    //////////////////////////////////////////////////

    localparam int DATA_W = 32;
    // Width of the crate register space
    localparam int ADDR_W = 27;
    localparam int TAG_W  = 4;

    //////////////////////////////////////////////////
    // Request and response encodings
    //////////////////////////////////////////////////

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    // Returned with every tag, read data only valid with ST_OK
    typedef enum logic [1:0] {
        ST_OK      = 2'd0,
        ST_INVALID = 2'd1,
        ST_TIMEOUT = 2'd2
    } status_e;

endpackage

// File: hdl/link_pkg.sv
package link_pkg;

    // Top address bits pick the TURFIO link
    localparam int LINK_SEL_W = 2;
    // What is left of the address goes out on the link
    localparam int LINK_ADDR_W = bridge_pkg::ADDR_W - LINK_SEL_W;

    // One channel per TURFIO in the crate
    localparam int NUM_LINKS_DEFAULT = 4;

    // Per-channel transaction state
    typedef enum logic [1:0] {
        CH_IDLE = 2'd0,
        CH_WAIT = 2'd1,
        CH_DONE = 2'd2
    } chan_state_e;

endpackage

// File: hdl/req_dispatch.sv
`timescale 1ns/1ps

module req_dispatch #(
    parameter int NUM_LINKS = 4,
    parameter int CMD_DEPTH = 4
) (
    input  logic                                 ps_clk,
    input  logic                                 rst_i,
    // Host request port
    input  logic                                 req_valid_i,
    input  bridge_pkg::op_e                      req_op_i,
    input  logic [bridge_pkg::ADDR_W-1:0]        req_addr_i,
    input  logic [bridge_pkg::DATA_W-1:0]        req_wdata_i,
    input  logic [bridge_pkg::TAG_W-1:0]         req_tag_i,
    output logic                                 req_ready_o,
    // Channel push, payload shared by all channels
    output logic [NUM_LINKS-1:0]                 chan_push_o,
    output bridge_pkg::op_e                      chan_op_o,
    output logic [link_pkg::LINK_ADDR_W-1:0]     chan_addr_o,
    output logic [bridge_pkg::DATA_W-1:0]        chan_wdata_o,
    output logic [bridge_pkg::TAG_W-1:0]         chan_tag_o,
    input  logic [NUM_LINKS-1:0]                 chan_credit_i
);

    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    logic [link_pkg::LINK_SEL_W-1:0] sel_idx;
    logic                            sel_ok;
    logic [CNT_W-1:0]                credit_q [NUM_LINKS];

    //////////////////////////////////////////////////
    // Address split and credit check
    //////////////////////////////////////////////////

    assign sel_idx = req_addr_i[bridge_pkg::ADDR_W-1 -: link_pkg::LINK_SEL_W];
    // Link indices past NUM_LINKS have no channel behind them
    assign sel_ok  = (sel_idx < NUM_LINKS);

    assign req_ready_o = sel_ok && (credit_q[sel_idx] != '0);

    assign chan_op_o    = req_op_i;
    assign chan_addr_o  = req_addr_i[link_pkg::LINK_ADDR_W-1:0];
    assign chan_wdata_o = req_wdata_i;
    assign chan_tag_o   = req_tag_i;

    //////////////////////////////////////////////////
    // Per-channel credit counters
    //////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_LINKS; i++) begin : g_credit
        assign chan_push_o[i] = req_valid_i && req_ready_o && (sel_idx == i);

        always_ff @(posedge ps_clk) begin
            if (rst_i) begin
                credit_q[i] <= CNT_W'(CMD_DEPTH);
            end else begin
                credit_q[i] <= credit_q[i] + CNT_W'(chan_credit_i[i])
                               - CNT_W'(chan_push_o[i]);
            end
        end

        // Credits come back from the channel, so they must never overrun the FIFO
        a_credit_range: assert property (@(posedge ps_clk) disable iff (rst_i)
            (credit_q[i] <= CNT_W'(CMD_DEPTH)) && (chan_push_o[i] -> credit_q[i] != '0));
    end

endmodule

// File: hdl/link_channel.sv
`timescale 1ns/1ps

module link_channel #(
    parameter int CMD_DEPTH      = 4,
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic                                 ps_clk,
    input  logic                                 rst_i,
    // Push side, from the dispatcher
    input  logic                                 push_i,
    input  bridge_pkg::op_e                      op_i,
    input  logic [link_pkg::LINK_ADDR_W-1:0]     addr_i,
    input  logic [bridge_pkg::DATA_W-1:0]        wdata_i,
    input  logic [bridge_pkg::TAG_W-1:0]         tag_i,
    output logic                                 credit_o,
    // Remote TURFIO link
    input  logic                                 link_up_i,
    output logic                                 link_cmd_valid_o,
    output bridge_pkg::op_e                      link_cmd_op_o,
    output logic [link_pkg::LINK_ADDR_W-1:0]     link_cmd_addr_o,
    output logic [bridge_pkg::DATA_W-1:0]        link_cmd_wdata_o,
    input  logic                                 link_rsp_valid_i,
    input  logic [bridge_pkg::DATA_W-1:0]        link_rsp_rdata_i,
    // Result, held until granted
    output logic                                 done_o,
    output logic [bridge_pkg::TAG_W-1:0]         done_tag_o,
    output bridge_pkg::status_e                  done_status_o,
    output logic [bridge_pkg::DATA_W-1:0]        done_rdata_o,
    input  logic                                 grant_i,
    // Sticky error flags
    input  logic                                 clear_flags_i,
    output logic                                 timeout_flag_o,
    output logic                                 invalid_flag_o
);

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);
    localparam int TMR_W = $clog2(TIMEOUT_CYCLES + 1);

    bridge_pkg::op_e                  op_mem    [CMD_DEPTH];
    logic [link_pkg::LINK_ADDR_W-1:0] addr_mem  [CMD_DEPTH];
    logic [bridge_pkg::DATA_W-1:0]    wdata_mem [CMD_DEPTH];
    logic [bridge_pkg::TAG_W-1:0]     tag_mem   [CMD_DEPTH];

    logic [PTR_W-1:0]      wr_ptr_q;
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [CNT_W-1:0]      count_q;
    link_pkg::chan_state_e state_q;
    logic [TMR_W-1:0]      timer_q;
    logic                  pop;
    logic                  timed_out;

    bridge_pkg::op_e               cur_op_q;
    logic [bridge_pkg::TAG_W-1:0]  cur_tag_q;
    bridge_pkg::status_e           status_q;
    logic [bridge_pkg::DATA_W-1:0] rdata_q;
    logic                          timeout_flag_q;
    logic                          invalid_flag_q;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(CMD_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // Command FIFO
    //////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (push_i) begin
            op_mem[wr_ptr_q]    <= op_i;
            addr_mem[wr_ptr_q]  <= addr_i;
            wdata_mem[wr_ptr_q] <= wdata_i;
            tag_mem[wr_ptr_q]   <= tag_i;
        end
    end

    // Pop whenever idle, the credit goes straight back
    assign pop      = (state_q == link_pkg::CH_IDLE) && (count_q != '0);
    assign credit_o = pop;

    // Command leaves on the pop cycle, straight from the FIFO head
    assign link_cmd_valid_o = pop && link_up_i;
    assign link_cmd_op_o    = op_mem[rd_ptr_q];
    assign link_cmd_addr_o  = addr_mem[rd_ptr_q];
    assign link_cmd_wdata_o = wdata_mem[rd_ptr_q];

    // A reply on the last cycle still wins over the timeout
    assign timed_out = (state_q == link_pkg::CH_WAIT) && !link_rsp_valid_i
                       && (timer_q == TMR_W'(TIMEOUT_CYCLES - 1));

    //////////////////////////////////////////////////
    // Transaction FSM
    //////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            state_q  <= link_pkg::CH_IDLE;
            timer_q  <= '0;
        end else begin
            if (push_i)
                wr_ptr_q <= ptr_next(wr_ptr_q);
            if (pop)
                rd_ptr_q <= ptr_next(rd_ptr_q);
            count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop);

            case (state_q)
                link_pkg::CH_IDLE: begin
                    if (pop) begin
                        timer_q <= '0;
                        state_q <= link_up_i ? link_pkg::CH_WAIT : link_pkg::CH_DONE;
                    end
                end
                link_pkg::CH_WAIT: begin
                    timer_q <= timer_q + 1'b1;
                    if (link_rsp_valid_i || timed_out)
                        state_q <= link_pkg::CH_DONE;
                end
                link_pkg::CH_DONE: begin
                    if (grant_i)
                        state_q <= link_pkg::CH_IDLE;
                end
                default: state_q <= link_pkg::CH_IDLE;
            endcase
        end
    end

    // Result payload, status defaults to invalid for a down link
    always_ff @(posedge ps_clk) begin
        if (pop) begin
            cur_op_q  <= op_mem[rd_ptr_q];
            cur_tag_q <= tag_mem[rd_ptr_q];
            status_q  <= bridge_pkg::ST_INVALID;
            rdata_q   <= '0;
        end else if (state_q == link_pkg::CH_WAIT) begin
            if (link_rsp_valid_i) begin
                status_q <= bridge_pkg::ST_OK;
                rdata_q  <= (cur_op_q == bridge_pkg::OP_READ) ? link_rsp_rdata_i : '0;
            end else if (timed_out) begin
                status_q <= bridge_pkg::ST_TIMEOUT;
            end
        end
    end

    assign done_o        = (state_q == link_pkg::CH_DONE);
    assign done_tag_o    = cur_tag_q;
    assign done_status_o = status_q;
    assign done_rdata_o  = rdata_q;

    //////////////////////////////////////////////////
    // Sticky flags
    //////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            timeout_flag_q <= 1'b0;
            invalid_flag_q <= 1'b0;
        end else begin
            if (clear_flags_i) begin
                timeout_flag_q <= 1'b0;
                invalid_flag_q <= 1'b0;
            end
            // New events win over a clear in the same cycle
            if (timed_out)
                timeout_flag_q <= 1'b1;
            if (pop && !link_up_i)
                invalid_flag_q <= 1'b1;
        end
    end

    assign timeout_flag_o = timeout_flag_q;
    assign invalid_flag_o = invalid_flag_q;

    // Dispatcher credits must keep pushes away from a full FIFO
    a_no_push_full: assert property (@(posedge ps_clk) disable iff (rst_i)
        push_i |-> (count_q != CNT_W'(CMD_DEPTH)));

endmodule

// File: hdl/resp_collect.sv
`timescale 1ns/1ps

module resp_collect #(
    parameter int NUM_LINKS = 4
) (
    input  logic                                          ps_clk,
    input  logic                                          rst_i,
    // Finished channel results
    input  logic [NUM_LINKS-1:0]                          done_i,
    input  logic [NUM_LINKS-1:0][bridge_pkg::TAG_W-1:0]   done_tag_i,
    input  bridge_pkg::status_e [NUM_LINKS-1:0]           done_status_i,
    input  logic [NUM_LINKS-1:0][bridge_pkg::DATA_W-1:0]  done_rdata_i,
    output logic [NUM_LINKS-1:0]                          grant_o,
    // Host response port
    output logic                                          rsp_valid_o,
    output logic [bridge_pkg::TAG_W-1:0]                  rsp_tag_o,
    output bridge_pkg::status_e                           rsp_status_o,
    output logic [bridge_pkg::DATA_W-1:0]                 rsp_rdata_o
);

    localparam int IDX_W = (NUM_LINKS > 1) ? $clog2(NUM_LINKS) : 1;

    logic [IDX_W-1:0] ptr_q;
    logic [IDX_W-1:0] gnt_idx;

    //////////////////////////////////////////////////
    // Round-robin pick, search starts after ptr_q
    //////////////////////////////////////////////////

    always_comb begin : rr_pick
        int unsigned idx;
        idx     = 0;
        grant_o = '0;
        gnt_idx = ptr_q;
        for (int k = 1; k <= NUM_LINKS; k++) begin
            idx = (int'(ptr_q) + k) % NUM_LINKS;
            if (done_i[idx] && (grant_o == '0)) begin
                grant_o[idx] = 1'b1;
                gnt_idx      = IDX_W'(idx);
            end
        end
    end

    //////////////////////////////////////////////////
    // Registered response
    //////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            rsp_valid_o <= 1'b0;
            // Link 0 gets the first turn
            ptr_q       <= IDX_W'(NUM_LINKS - 1);
        end else begin
            rsp_valid_o <= |grant_o;
            if (|grant_o)
                ptr_q <= gnt_idx;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (|grant_o) begin
            rsp_tag_o    <= done_tag_i[gnt_idx];
            rsp_status_o <= done_status_i[gnt_idx];
            rsp_rdata_o  <= done_rdata_i[gnt_idx];
        end
    end

    // At most one channel granted, and only one that is holding a result
    a_grant_onehot: assert property (@(posedge ps_clk) disable iff (rst_i)
        $onehot0(grant_o) && ((grant_o & ~done_i) == '0));

endmodule

// File: hdl/crate_bridge.sv
`timescale 1ns/1ps

module crate_bridge #(
    // At most 2**LINK_SEL_W links
    parameter int NUM_LINKS      = link_pkg::NUM_LINKS_DEFAULT,
    parameter int CMD_DEPTH      = 4,
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic                                                ps_clk,
    input  logic                                                rst_i,
    // Host request port
    input  logic                                                req_valid_i,
    input  bridge_pkg::op_e                                     req_op_i,
    input  logic [bridge_pkg::ADDR_W-1:0]                       req_addr_i,
    input  logic [bridge_pkg::DATA_W-1:0]                       req_wdata_i,
    input  logic [bridge_pkg::TAG_W-1:0]                        req_tag_i,
    output logic                                                req_ready_o,
    // Host response port, no back-pressure
    output logic                                                rsp_valid_o,
    output logic [bridge_pkg::TAG_W-1:0]                        rsp_tag_o,
    output bridge_pkg::status_e                                 rsp_status_o,
    output logic [bridge_pkg::DATA_W-1:0]                       rsp_rdata_o,
    // TURFIO links, one slot each
    output logic [NUM_LINKS-1:0]                                link_cmd_valid_o,
    output bridge_pkg::op_e [NUM_LINKS-1:0]                     link_cmd_op_o,
    output logic [NUM_LINKS-1:0][link_pkg::LINK_ADDR_W-1:0]     link_cmd_addr_o,
    output logic [NUM_LINKS-1:0][bridge_pkg::DATA_W-1:0]        link_cmd_wdata_o,
    input  logic [NUM_LINKS-1:0]                                link_rsp_valid_i,
    input  logic [NUM_LINKS-1:0][bridge_pkg::DATA_W-1:0]        link_rsp_rdata_i,
    input  logic [NUM_LINKS-1:0]                                link_up_i,
    // Error flags
    input  logic                                                clear_flags_i,
    output logic [NUM_LINKS-1:0]                                timeout_flags_o,
    output logic [NUM_LINKS-1:0]                                invalid_flags_o
);

    logic [NUM_LINKS-1:0]                         chan_push;
    bridge_pkg::op_e                              chan_op;
    logic [link_pkg::LINK_ADDR_W-1:0]             chan_addr;
    logic [bridge_pkg::DATA_W-1:0]                chan_wdata;
    logic [bridge_pkg::TAG_W-1:0]                 chan_tag;
    logic [NUM_LINKS-1:0]                         chan_credit;

    logic [NUM_LINKS-1:0]                         done;
    logic [NUM_LINKS-1:0][bridge_pkg::TAG_W-1:0]  done_tag;
    bridge_pkg::status_e [NUM_LINKS-1:0]          done_status;
    logic [NUM_LINKS-1:0][bridge_pkg::DATA_W-1:0] done_rdata;
    logic [NUM_LINKS-1:0]                         grant;

    req_dispatch #(
        .NUM_LINKS (NUM_LINKS),
        .CMD_DEPTH (CMD_DEPTH)
    ) u_dispatch (
        .ps_clk        (ps_clk),
        .rst_i         (rst_i),
        .req_valid_i   (req_valid_i),
        .req_op_i      (req_op_i),
        .req_addr_i    (req_addr_i),
        .req_wdata_i   (req_wdata_i),
        .req_tag_i     (req_tag_i),
        .req_ready_o   (req_ready_o),
        .chan_push_o   (chan_push),
        .chan_op_o     (chan_op),
        .chan_addr_o   (chan_addr),
        .chan_wdata_o  (chan_wdata),
        .chan_tag_o    (chan_tag),
        .chan_credit_i (chan_credit)
    );

    //////////////////////////////////////////////////
    // One channel per link
    //////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_LINKS; i++) begin : g_link
        link_channel #(
            .CMD_DEPTH      (CMD_DEPTH),
            .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
        ) u_chan (
            .ps_clk           (ps_clk),
            .rst_i            (rst_i),
            .push_i           (chan_push[i]),
            .op_i             (chan_op),
            .addr_i           (chan_addr),
            .wdata_i          (chan_wdata),
            .tag_i            (chan_tag),
            .credit_o         (chan_credit[i]),
            .link_up_i        (link_up_i[i]),
            .link_cmd_valid_o (link_cmd_valid_o[i]),
            .link_cmd_op_o    (link_cmd_op_o[i]),
            .link_cmd_addr_o  (link_cmd_addr_o[i]),
            .link_cmd_wdata_o (link_cmd_wdata_o[i]),
            .link_rsp_valid_i (link_rsp_valid_i[i]),
            .link_rsp_rdata_i (link_rsp_rdata_i[i]),
            .done_o           (done[i]),
            .done_tag_o       (done_tag[i]),
            .done_status_o    (done_status[i]),
            .done_rdata_o     (done_rdata[i]),
            .grant_i          (grant[i]),
            .clear_flags_i    (clear_flags_i),
            .timeout_flag_o   (timeout_flags_o[i]),
            .invalid_flag_o   (invalid_flags_o[i])
        );
    end

    resp_collect #(
        .NUM_LINKS (NUM_LINKS)
    ) u_collect (
        .ps_clk        (ps_clk),
        .rst_i         (rst_i),
        .done_i        (done),
        .done_tag_i    (done_tag),
        .done_status_i (done_status),
        .done_rdata_i  (done_rdata),
        .grant_o       (grant),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_tag_o     (rsp_tag_o),
        .rsp_status_o  (rsp_status_o),
        .rsp_rdata_o   (rsp_rdata_o)
    );

endmodule

// File: verif/turfio_model.sv
`timescale 1ns/1ps

module turfio_model #(
    parameter logic [31:0] LINK_KEY = 32'h0
) (
    input  logic                                 ps_clk,
    input  logic                                 rst_i,
    input  logic                                 mute_i,
    input  logic                                 cmd_valid_i,
    input  bridge_pkg::op_e                      cmd_op_i,
    input  logic [link_pkg::LINK_ADDR_W-1:0]     cmd_addr_i,
    input  logic [bridge_pkg::DATA_W-1:0]        cmd_wdata_i,
    output logic                                 rsp_valid_o,
    output logic [bridge_pkg::DATA_W-1:0]        rsp_rdata_o
);

    localparam int DW  = bridge_pkg::DATA_W;
    localparam int LAW = link_pkg::LINK_ADDR_W;

    logic [DW-1:0] mem [logic [LAW-1:0]];
    logic [DW-1:0] reply;
    logic          pending;
    int            delay;

    // Untouched words read back as the address mixed with the link key
    function automatic logic [DW-1:0] read_word(input logic [LAW-1:0] a);
        if (mem.exists(a))
            return mem[a];
        return DW'(a) ^ LINK_KEY;
    endfunction

    initial begin
        rsp_valid_o = 1'b0;
        rsp_rdata_o = '0;
        reply       = '0;
        pending     = 1'b0;
        delay       = 0;
    end

    // Commands are taken on the rising edge like a register would
    always @(posedge ps_clk) begin
        if (!rst_i && cmd_valid_i) begin
            if (cmd_op_i == bridge_pkg::OP_WRITE) begin
                mem[cmd_addr_i] = cmd_wdata_i;
                reply = '0;
            end else begin
                reply = read_word(cmd_addr_i);
            end
            delay   = int'($urandom_range(20, 1));
            pending = 1'b1;
        end
    end

    // Replies go out on the falling edge, a muted link drops its command
    always @(negedge ps_clk) begin
        rsp_valid_o <= 1'b0;
        if (rst_i || mute_i) begin
            pending = 1'b0;
        end else if (pending) begin
            delay = delay - 1;
            if (delay == 0) begin
                rsp_valid_o <= 1'b1;
                rsp_rdata_o <= reply;
                pending = 1'b0;
            end
        end
    end

endmodule

// File: verif/crate_bridge_tb.sv
`timescale 1ns/1ps

module crate_bridge_tb;

    localparam int NUM_LINKS      = 4;
    localparam int CMD_DEPTH      = 4;
    localparam int TIMEOUT_CYCLES = 64;
    localparam int DW  = bridge_pkg::DATA_W;
    localparam int AW  = bridge_pkg::ADDR_W;
    localparam int SW  = link_pkg::LINK_SEL_W;
    localparam int LAW = link_pkg::LINK_ADDR_W;
    localparam int NUM_TAGS = 2 ** bridge_pkg::TAG_W;
    // Requests over all five tests
    localparam int N_REQ = 32 + 32 + 6 + 16 + 12;

    logic                                 ps_clk;
    logic                                 rst_i;
    logic                                 req_valid_i;
    bridge_pkg::op_e                      req_op_i;
    logic [AW-1:0]                        req_addr_i;
    logic [DW-1:0]                        req_wdata_i;
    logic [bridge_pkg::TAG_W-1:0]         req_tag_i;
    logic                                 req_ready_o;
    logic                                 rsp_valid_o;
    logic [bridge_pkg::TAG_W-1:0]         rsp_tag_o;
    bridge_pkg::status_e                  rsp_status_o;
    logic [DW-1:0]                        rsp_rdata_o;
    logic [NUM_LINKS-1:0]                 link_cmd_valid_o;
    bridge_pkg::op_e [NUM_LINKS-1:0]      link_cmd_op_o;
    logic [NUM_LINKS-1:0][LAW-1:0]        link_cmd_addr_o;
    logic [NUM_LINKS-1:0][DW-1:0]         link_cmd_wdata_o;
    logic [NUM_LINKS-1:0]                 link_rsp_valid_i;
    logic [NUM_LINKS-1:0][DW-1:0]         link_rsp_rdata_i;
    logic [NUM_LINKS-1:0]                 link_up_i;
    logic                                 clear_flags_i;
    logic [NUM_LINKS-1:0]                 timeout_flags_o;
    logic [NUM_LINKS-1:0]                 invalid_flags_o;
    logic [NUM_LINKS-1:0]                 mute;

    // Scoreboard, indexed by tag
    logic                tag_busy   [NUM_TAGS];
    bridge_pkg::status_e exp_status [NUM_TAGS];
    logic [DW-1:0]       exp_rdata  [NUM_TAGS];
    int                  exp_link   [NUM_TAGS];
    int                  exp_seq    [NUM_TAGS];
    int                  issue_seq  [NUM_LINKS];
    int                  answer_seq [NUM_LINKS];
    int                  cmd_cnt    [NUM_LINKS];
    logic [DW-1:0]       shadow [logic [AW-1:0]];
    logic [LAW-1:0]      pool [8];

    int outstanding, timeout_wait, ok_while_muted, stall_cnt;
    int err_cnt, err_mark, pass_cnt, fail_cnt, test_no, mark;

    crate_bridge #(
        .NUM_LINKS      (NUM_LINKS),
        .CMD_DEPTH      (CMD_DEPTH),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) crate_bridge_i (.*);

    for (genvar i = 0; i < NUM_LINKS; i++) begin : g_remote
        turfio_model #(
            .LINK_KEY (32'h3c5a_0000 + 32'h0111_0f0f * i)
        ) u_remote (
            .ps_clk      (ps_clk),
            .rst_i       (rst_i),
            .mute_i      (mute[i]),
            .cmd_valid_i (link_cmd_valid_o[i]),
            .cmd_op_i    (link_cmd_op_o[i]),
            .cmd_addr_i  (link_cmd_addr_o[i]),
            .cmd_wdata_i (link_cmd_wdata_o[i]),
            .rsp_valid_o (link_rsp_valid_i[i]),
            .rsp_rdata_o (link_rsp_rdata_i[i])
        );
    end

    always #10 ps_clk = ~ps_clk;

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic [DW-1:0] init_word(input int l, input logic [LAW-1:0] la);
        logic [DW-1:0] key;
        key = 32'h3c5a_0000 + 32'h0111_0f0f * l;
        return DW'(la) ^ key;
    endfunction

    function automatic void predict(input int tag, input bridge_pkg::op_e op, input int l,
                                    input logic [AW-1:0] a, input logic [DW-1:0] wd);
        exp_link[tag]  = l;
        exp_seq[tag]   = issue_seq[l];
        issue_seq[l]++;
        exp_rdata[tag] = '0;
        if (!link_up_i[l]) begin
            exp_status[tag] = bridge_pkg::ST_INVALID;
        end else if (mute[l]) begin
            exp_status[tag] = bridge_pkg::ST_TIMEOUT;
            timeout_wait++;
        end else begin
            exp_status[tag] = bridge_pkg::ST_OK;
            if (op == bridge_pkg::OP_WRITE)
                shadow[a] = wd;
            else
                exp_rdata[tag] = shadow.exists(a) ? shadow[a] : init_word(l, a[LAW-1:0]);
        end
    endfunction

    function automatic bridge_pkg::op_e rand_op();
        return ($urandom_range(1, 0) == 1) ? bridge_pkg::OP_WRITE : bridge_pkg::OP_READ;
    endfunction

    //////////////////////////////////////////////////
    // Host driver tasks
    //////////////////////////////////////////////////

    // Called on a falling edge, returns on the falling edge after the handshake
    task automatic send_req(input bridge_pkg::op_e op, input int l,
                            input logic [LAW-1:0] la, input logic [DW-1:0] wd);
        int tag;
        tag = -1;
        while (tag < 0) begin
            for (int t = 0; t < NUM_TAGS; t++) begin
                if (!tag_busy[t] && tag < 0)
                    tag = t;
            end
            if (tag < 0)
                @(negedge ps_clk);
        end
        tag_busy[tag] = 1'b1;
        outstanding++;
        req_valid_i = 1'b1;
        req_op_i    = op;
        req_addr_i  = {SW'(l), la};
        req_wdata_i = wd;
        req_tag_i   = bridge_pkg::TAG_W'(tag);
        // Ready only moves on a rising edge, so look at it mid-cycle
        #1;
        while (!req_ready_o) begin
            stall_cnt++;
            @(negedge ps_clk);
            #1;
        end
        @(posedge ps_clk);
        predict(tag, op, l, req_addr_i, wd);
        @(negedge ps_clk);
        req_valid_i = 1'b0;
    endtask

    task automatic drain();
        while (outstanding != 0)
            @(negedge ps_clk);
    endtask

    task automatic pulse_clear();
        clear_flags_i = 1'b1;
        @(negedge ps_clk);
        clear_flags_i = 1'b0;
        @(negedge ps_clk);
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = err_cnt - err_mark;
        if (errs == 0) begin
            pass_cnt++;
            $display("Test %0d %s: PASS", test_no, name);
        end else begin
            fail_cnt++;
            $display("Test %0d %s: FAIL with %0d errors", test_no, name, errs);
        end
        test_no++;
        err_mark = err_cnt;
    endtask

    //////////////////////////////////////////////////
    // Monitors
    //////////////////////////////////////////////////

    always @(posedge ps_clk) begin
        for (int l = 0; l < NUM_LINKS; l++) begin
            if (link_cmd_valid_o[l])
                cmd_cnt[l]++;
        end
    end

    // Responses are registered, so the falling edge sees each one once
    always @(negedge ps_clk) begin : rsp_check
        int t;
        if (rsp_valid_o) begin
            t = int'(rsp_tag_o);
            if (!tag_busy[t]) begin
                $display("Response for tag %0d arrived with no request outstanding", t);
                err_cnt++;
            end else begin
                if (rsp_status_o !== exp_status[t] || rsp_rdata_o !== exp_rdata[t]) begin
                    $display("[ERROR] %0t: tag %0d got status %0d data %08h, expected %0d %08h",
                             $time, t, rsp_status_o, rsp_rdata_o, exp_status[t], exp_rdata[t]);
                    err_cnt++;
                end
                if (exp_seq[t] != answer_seq[exp_link[t]]) begin
                    $display("Link %0d answered tag %0d out of request order", exp_link[t], t);
                    err_cnt++;
                end
                answer_seq[exp_link[t]]++;
                if (exp_status[t] == bridge_pkg::ST_TIMEOUT)
                    timeout_wait--;
                else if (timeout_wait > 0 && rsp_status_o == bridge_pkg::ST_OK)
                    ok_while_muted++;
                tag_busy[t] = 1'b0;
                outstanding--;
            end
        end
    end

    initial begin : watchdog
        repeat (N_REQ * (TIMEOUT_CYCLES + 40)) @(posedge ps_clk);
        $display("Watchdog expired before all responses came back");
        $display("tests failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h92a1bc4a));
        ps_clk = 1'b0;
        rst_i = 1'b1;
        req_valid_i = 1'b0;
        req_op_i = bridge_pkg::OP_READ;
        req_addr_i = '0;
        req_wdata_i = '0;
        req_tag_i = '0;
        link_up_i = '1;
        mute = '0;
        clear_flags_i = 1'b0;
        for (int t = 0; t < NUM_TAGS; t++)
            tag_busy[t] = 1'b0;
        for (int l = 0; l < NUM_LINKS; l++) begin
            issue_seq[l] = 0;
            answer_seq[l] = 0;
            cmd_cnt[l] = 0;
        end
        for (int k = 0; k < 8; k++)
            pool[k] = LAW'($urandom());
        {outstanding, timeout_wait, ok_while_muted, stall_cnt} = '0;
        {err_cnt, err_mark, pass_cnt, fail_cnt} = '0;
        test_no = 1;
        repeat (8) @(negedge ps_clk);
        rst_i = 1'b0;
        @(negedge ps_clk);

        if (req_ready_o !== 1'b1 || rsp_valid_o !== 1'b0 || link_cmd_valid_o !== '0) begin
            $display("[ERROR] %0t: port levels after reset are wrong", $time);
            err_cnt++;
        end
        repeat (32) send_req(bridge_pkg::OP_READ, int'($urandom_range(3, 0)),
                             LAW'($urandom()), '0);
        drain();
        end_test("reads on up links");

        repeat (16) send_req(bridge_pkg::OP_WRITE, int'($urandom_range(3, 0)),
                             pool[$urandom_range(7, 0)], $urandom());
        repeat (16) send_req(bridge_pkg::OP_READ, int'($urandom_range(3, 0)),
                             pool[$urandom_range(7, 0)], '0);
        drain();
        end_test("write then read back");

        link_up_i[2] = 1'b0;
        mark = cmd_cnt[2];
        repeat (6) send_req(rand_op(), 2, LAW'($urandom()), $urandom());
        drain();
        if (cmd_cnt[2] != mark) begin
            $display("Link 2 sent a command while it was down");
            err_cnt++;
        end
        if (invalid_flags_o[2] !== 1'b1) begin
            $display("[ERROR] %0t: invalid flag of link 2 did not set", $time);
            err_cnt++;
        end
        pulse_clear();
        if (invalid_flags_o[2] !== 1'b0) begin
            $display("[ERROR] %0t: invalid flag of link 2 did not clear", $time);
            err_cnt++;
        end
        link_up_i[2] = 1'b1;
        end_test("down link");

        mute[1] = 1'b1;
        for (int k = 0; k < 16; k++) begin
            if (k % 4 == 0)
                send_req(bridge_pkg::OP_READ, 1, LAW'($urandom()), '0);
            else
                send_req(bridge_pkg::OP_READ, (k % 3 == 0) ? 0 : k % 3 + 1,
                         LAW'($urandom()), '0);
        end
        drain();
        if (timeout_flags_o[1] !== 1'b1) begin
            $display("[ERROR] %0t: timeout flag of link 1 did not set", $time);
            err_cnt++;
        end
        if (ok_while_muted == 0) begin
            $display("No other link answered while link 1 was muted");
            err_cnt++;
        end
        mute[1] = 1'b0;
        pulse_clear();
        if (timeout_flags_o !== '0) begin
            $display("[ERROR] %0t: timeout flags did not clear", $time);
            err_cnt++;
        end
        end_test("muted link");

        // Small address set so reads and writes on link 3 depend on order
        mark = stall_cnt;
        for (int k = 0; k < 12; k++)
            send_req(rand_op(), 3, pool[k % 4], $urandom());
        drain();
        if (stall_cnt == mark) begin
            $display("req_ready_o never dropped during the burst to link 3");
            err_cnt++;
        end
        end_test("back-pressure and order");

        $display("Summary: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: verilog.f
hdl/bridge_pkg.sv
hdl/link_pkg.sv
hdl/req_dispatch.sv
hdl/link_channel.sv
hdl/resp_collect.sv
hdl/crate_bridge.sv
verif/turfio_model.sv
verif/crate_bridge_tb.sv

// File: Makefile
TOP = crate_bridge_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
